/* vlog.f */
verilog/mgnt_pkg.sv
verilog/stat_capture.sv
verilog/req_decode.sv
verilog/counter_bank.sv
verilog/resp_serializer.sv
verilog/switch_ctrl.sv
tb/switch_ctrl_tb.sv

/* Bender.yml */
package:
  name: switch_ctrl

sources:
  - verilog/mgnt_pkg.sv
  - verilog/stat_capture.sv
  - verilog/req_decode.sv
  - verilog/counter_bank.sv
  - verilog/resp_serializer.sv
  - verilog/switch_ctrl.sv
  - target: simulation
    files:
      - tb/switch_ctrl_tb.sv

/* tb/switch_ctrl_tb.sv */
module switch_ctrl_tb import mgnt_pkg::*;;

    localparam int REG_W   = 32;
    localparam int NBYTES  = REG_W / BYTE_W;
    localparam int TIMEOUT = 200;

    localparam logic [2:0] K_FP       = 3'd0;
    localparam logic [2:0] K_FP_RAND  = 3'd1;
    localparam logic [2:0] K_SWC      = 3'd2;
    localparam logic [2:0] K_SWC_RAND = 3'd3;
    localparam logic [2:0] K_WR       = 3'd4;
    localparam logic [2:0] K_RD       = 3'd5;
    localparam logic [2:0] K_SWEEP    = 3'd6;

    // signals probed by the wait loop
    localparam int SIG_ACK      = 0;
    localparam int SIG_FP_RESP  = 1;
    localparam int SIG_SWC_RESP = 2;
    localparam int SIG_CONF     = 3;

    // data holds a word, or a count for the random rows; exp is a read
    // value or the number of config beats a write must produce
    typedef struct packed {
        logic [2:0]  kind;
        addr_t       addr;
        logic [31:0] data;
        logic [31:0] exp;
    } row_t;

    logic                   clk_if;
    logic                   rst_if;
    logic                   fp_stat_valid;
    logic                   fp_stat_resp;
    logic [FP_STAT_W-1:0]   fp_stat_data;
    logic                   fp_conf_valid;
    logic                   fp_conf_resp;
    logic [CONF_TYPE_W-1:0] fp_conf_type;
    logic [CONF_DATA_W-1:0] fp_conf_data;
    logic                   swc_stat_valid;
    logic                   swc_stat_resp;
    logic [SWC_STAT_W-1:0]  swc_stat_data;
    logic                   sys_req_valid;
    logic                   sys_req_wr;
    addr_t                  sys_req_addr;
    logic                   sys_req_ack;
    logic [BYTE_W-1:0]      sys_req_data;
    logic                   sys_req_data_valid;
    logic [BYTE_W-1:0]      sys_resp_data;
    logic                   sys_resp_data_valid;

    row_t              table_q[$];
    logic [31:0]       rng;
    logic [REG_W-1:0]  fp_model   [8];
    logic [REG_W-1:0]  swc_model  [5];
    logic [REG_W-1:0]  conf_model [3];
    logic [REG_W-1:0]  got;
    logic              conf_prev;
    int                conf_beats;

    switch_ctrl #(.REG_WIDTH(REG_W)) i_switch_ctrl (.*);

    initial clk_if = 1'b0;
    always #20 clk_if = ~clk_if;

    // counts rising edges of conf_valid
    always @(posedge clk_if) begin
        if (!rst_if) begin
            conf_prev  <= 1'b0;
            conf_beats <= 0;
        end else begin
            conf_prev <= fp_conf_valid;
            if (fp_conf_valid && !conf_prev) begin
                conf_beats <= conf_beats + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic probe_signal(input int sel);
        case (sel)
            SIG_ACK:      return sys_req_ack;
            SIG_FP_RESP:  return fp_stat_resp;
            SIG_SWC_RESP: return swc_stat_resp;
            default:      return fp_conf_valid;
        endcase
    endfunction

    // expected register map contents, zero where nothing is mapped
    function automatic logic [REG_W-1:0] model_value(input addr_t a);
        if (a <= 8'h07) return fp_model[a[2:0]];
        if (a >= 8'h08 && a <= 8'h0A) return conf_model[a[1:0]];
        if (a >= 8'h10 && a <= 8'h14) return swc_model[a[2:0]];
        return '0;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [REG_W-1:0] got_w,
                              input logic [REG_W-1:0] exp_w);
        if (got_w !== exp_w) begin
            stop_on_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got_w, exp_w));
        end
    endtask

    task automatic check_beat(input logic [CONF_TYPE_W-1:0] got_type,
                              input logic [CONF_TYPE_W-1:0] exp_type,
                              input logic [CONF_DATA_W-1:0] got_data,
                              input logic [CONF_DATA_W-1:0] exp_data);
        if (got_type !== exp_type || got_data !== exp_data) begin
            stop_on_error($sformatf("ERR fp_conf_type/fp_conf_data got 0x%h/0x%h expected 0x%h/0x%h",
                                    got_type, got_data, exp_type, exp_data));
        end
    endtask

    task automatic wait_until(input int sel, input logic level, input string what);
        int t;
        t = 0;
        while (probe_signal(sel) !== level) begin
            t++;
            if (t > TIMEOUT) stop_on_error(what);
            @(posedge clk_if);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // status sources

    task automatic send_fp_status(input logic [FP_STAT_W-1:0] w);
        @(posedge clk_if);
        fp_stat_valid <= 1'b1;
        fp_stat_data  <= w;
        @(posedge clk_if);
        wait_until(SIG_FP_RESP, 1'b1, "fp_stat_resp never rose");
        fp_stat_valid <= 1'b0;
        @(posedge clk_if);
        wait_until(SIG_FP_RESP, 1'b0, "fp_stat_resp never fell");
        fp_model[0] = fp_model[0] + w[0];
        fp_model[1] = fp_model[1] + w[1];
        fp_model[2] = fp_model[2] + w[2];
        fp_model[3] = fp_model[3] + w[5];
        fp_model[4] = fp_model[4] + w[6];
        // destination miss and invalid MAC count a cleared bit
        fp_model[5] = fp_model[5] + !w[3];
        fp_model[6] = fp_model[6] + w[7];
        fp_model[7] = fp_model[7] + !w[4];
    endtask

    task automatic send_swc_status(input logic [SWC_STAT_W-1:0] w);
        @(posedge clk_if);
        swc_stat_valid <= 1'b1;
        swc_stat_data  <= w;
        @(posedge clk_if);
        wait_until(SIG_SWC_RESP, 1'b1, "swc_stat_resp never rose");
        swc_stat_valid <= 1'b0;
        @(posedge clk_if);
        wait_until(SIG_SWC_RESP, 1'b0, "swc_stat_resp never fell");
        swc_model[0] = swc_model[0] + (w[2:0] == 3'b000);
        for (int i = 0; i < 4; i++) begin
            swc_model[i+1] = swc_model[i+1] + w[i];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host side and config endpoint

    task automatic answer_conf(output logic [CONF_TYPE_W-1:0] got_type,
                               output logic [CONF_DATA_W-1:0] got_data);
        wait_until(SIG_CONF, 1'b1, "no config beat after a config register write");
        got_type = fp_conf_type;
        got_data = fp_conf_data;
        // hold resp back, the write has to stall meanwhile
        repeat (3) begin
            @(posedge clk_if);
            if (sys_req_ack || !fp_conf_valid) begin
                stop_on_error("config write finished before the endpoint answered");
            end
        end
        fp_conf_resp <= 1'b1;
        wait_until(SIG_CONF, 1'b0, "conf_valid stayed high after the endpoint answered");
        fp_conf_resp <= 1'b0;
    endtask

    task automatic read_register(input addr_t a, output logic [REG_W-1:0] word);
        int t;
        int n;
        @(posedge clk_if);
        sys_req_valid <= 1'b1;
        sys_req_wr    <= 1'b0;
        sys_req_addr  <= a;
        t = 0;
        @(posedge clk_if);
        while (!sys_resp_data_valid) begin
            t++;
            if (t > TIMEOUT) stop_on_error("read data never arrived");
            @(posedge clk_if);
        end
        n    = 0;
        word = '0;
        while (sys_resp_data_valid) begin
            word = {word[REG_W-BYTE_W-1:0], sys_resp_data};
            n++;
            if (n > NBYTES) stop_on_error("read burst ran past the end of the word");
            @(posedge clk_if);
        end
        if (n != NBYTES) begin
            stop_on_error($sformatf("ERR sys_resp_data_valid cycles got 0x%h expected 0x%h",
                                    n, NBYTES));
        end
        wait_until(SIG_ACK, 1'b1, "req_ack never rose after a read");
        sys_req_valid <= 1'b0;
        @(posedge clk_if);
        wait_until(SIG_ACK, 1'b0, "req_ack stayed high after req_valid fell");
    endtask

    task automatic write_register(input addr_t a, input logic [REG_W-1:0] w,
                                  input int exp_beats);
        int gap;
        int beats_before;
        logic [CONF_TYPE_W-1:0] got_type;
        logic [CONF_DATA_W-1:0] got_data;
        beats_before = conf_beats;
        @(posedge clk_if);
        sys_req_valid <= 1'b1;
        sys_req_wr    <= 1'b1;
        sys_req_addr  <= a;
        // bytes go out most significant first, with random gaps
        for (int i = NBYTES - 1; i >= 0; i--) begin
            rng = xorshift(rng);
            gap = rng % 3;
            @(posedge clk_if);
            sys_req_data_valid <= 1'b0;
            repeat (gap) @(posedge clk_if);
            sys_req_data       <= w[i*BYTE_W +: BYTE_W];
            sys_req_data_valid <= 1'b1;
        end
        @(posedge clk_if);
        sys_req_data_valid <= 1'b0;
        if (exp_beats != 0) begin
            answer_conf(got_type, got_data);
            check_beat(got_type, a[1:0], got_data, w[CONF_DATA_W-1:0]);
            conf_model[a[1:0]] = w;
        end
        wait_until(SIG_ACK, 1'b1, "req_ack never rose after a write");
        sys_req_valid <= 1'b0;
        @(posedge clk_if);
        wait_until(SIG_ACK, 1'b0, "req_ack stayed high after req_valid fell");
        if (conf_beats - beats_before != exp_beats) begin
            stop_on_error($sformatf("ERR fp_conf_valid beats got 0x%h expected 0x%h",
                                    conf_beats - beats_before, exp_beats));
        end
    endtask

    // whole address range, mapped and unmapped, against the model
    task automatic sweep_registers();
        logic [REG_W-1:0] word;
        for (int a = 0; a < 8'h16; a++) begin
            read_register(addr_t'(a), word);
            check_word($sformatf("sys_resp_data word at 0x%h", a), word, model_value(addr_t'(a)));
        end
    endtask

    task automatic add_row(input logic [2:0] kind, input addr_t addr,
                           input logic [31:0] data, input logic [31:0] exp);
        table_q.push_back({kind, addr, data, exp});
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        rst_if             = 1'b0;
        fp_stat_valid      = 1'b0;
        fp_stat_data       = '0;
        fp_conf_resp       = 1'b0;
        swc_stat_valid     = 1'b0;
        swc_stat_data      = '0;
        sys_req_valid      = 1'b0;
        sys_req_wr         = 1'b0;
        sys_req_addr       = '0;
        sys_req_data       = '0;
        sys_req_data_valid = 1'b0;
        rng                = 32'hedba;
        for (int i = 0; i < 8; i++) fp_model[i] = '0;
        for (int i = 0; i < 5; i++) swc_model[i] = '0;
        for (int i = 0; i < 3; i++) conf_model[i] = '0;

        add_row(K_SWEEP,    8'h00, 32'h0,         32'h0);
        add_row(K_FP,       8'h00, 32'h01,        32'h0);
        add_row(K_FP,       8'h00, 32'h1A,        32'h0);
        add_row(K_FP,       8'h00, 32'h00,        32'h0);
        add_row(K_FP,       8'h00, 32'hFF,        32'h0);
        add_row(K_FP_RAND,  8'h00, 32'd24,        32'h0);
        add_row(K_SWC,      8'h00, 32'h0,         32'h0);
        add_row(K_SWC,      8'h00, 32'h8,         32'h0);
        add_row(K_SWC,      8'h00, 32'hF,         32'h0);
        add_row(K_SWC_RAND, 8'h00, 32'd12,        32'h0);
        add_row(K_SWEEP,    8'h00, 32'h0,         32'h0);
        add_row(K_WR,       8'h08, 32'hDEADBEEF,  32'd1);
        add_row(K_WR,       8'h09, 32'h00000001,  32'd1);
        add_row(K_WR,       8'h0A, 32'h1234ABCD,  32'd1);
        add_row(K_RD,       8'h08, 32'h0,         32'hDEADBEEF);
        add_row(K_RD,       8'h0A, 32'h0,         32'h1234ABCD);
        add_row(K_WR,       8'h00, 32'hFFFFFFFF,  32'd0);
        add_row(K_WR,       8'h12, 32'h55555555,  32'd0);
        add_row(K_WR,       8'h0F, 32'hA5A5A5A5,  32'd0);
        add_row(K_SWEEP,    8'h00, 32'h0,         32'h0);

        repeat (2) @(posedge clk_if);
        rst_if <= 1'b1;

        foreach (table_q[i]) begin
            case (table_q[i].kind)
                K_FP:      send_fp_status(table_q[i].data[FP_STAT_W-1:0]);
                K_FP_RAND: begin
                    repeat (table_q[i].data) begin
                        rng = xorshift(rng);
                        send_fp_status(rng[FP_STAT_W-1:0]);
                    end
                end
                K_SWC:      send_swc_status(table_q[i].data[SWC_STAT_W-1:0]);
                K_SWC_RAND: begin
                    repeat (table_q[i].data) begin
                        rng = xorshift(rng);
                        send_swc_status(rng[SWC_STAT_W+7:8]);
                    end
                end
                K_WR: write_register(table_q[i].addr, table_q[i].data, table_q[i].exp);
                K_RD: begin
                    read_register(table_q[i].addr, got);
                    check_word($sformatf("sys_resp_data word at 0x%h", table_q[i].addr),
                               got, table_q[i].exp);
                end
                default: sweep_registers();
            endcase
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog/switch_ctrl.sv */
module switch_ctrl import mgnt_pkg::*; #(
    parameter int REG_WIDTH = mgnt_pkg::REG_WIDTH
) (
    input  logic                   clk_if,
    input  logic                   rst_if,
    // frame-processing side
    input  logic                   fp_stat_valid,
    output logic                   fp_stat_resp,
    input  logic [FP_STAT_W-1:0]   fp_stat_data,
    output logic                   fp_conf_valid,
    input  logic                   fp_conf_resp,
    output logic [CONF_TYPE_W-1:0] fp_conf_type,
    output logic [CONF_DATA_W-1:0] fp_conf_data,
    // switch core side
    input  logic                   swc_stat_valid,
    output logic                   swc_stat_resp,
    input  logic [SWC_STAT_W-1:0]  swc_stat_data,
    // system host
    input  logic                   sys_req_valid,
    input  logic                   sys_req_wr,
    input  addr_t                  sys_req_addr,
    output logic                   sys_req_ack,
    input  logic [BYTE_W-1:0]      sys_req_data,
    input  logic                   sys_req_data_valid,
    output logic [BYTE_W-1:0]      sys_resp_data,
    output logic                   sys_resp_data_valid
);

    logic                  fp_event;
    logic [FP_STAT_W-1:0]  fp_word;
    logic                  swc_event;
    logic [SWC_STAT_W-1:0] swc_word;
    addr_t                 cmd_addr;
    logic                  rd_start;
    logic                  rd_done;
    logic [REG_WIDTH-1:0]  rd_word;
    logic [REG_WIDTH-1:0]  wr_word;
    logic                  wr_commit;
    logic                  wr_done;

    stat_capture #(.STAT_W(FP_STAT_W)) i_fp_stat (
        .clk_if      (clk_if),
        .rst_if      (rst_if),
        .stat_valid  (fp_stat_valid),
        .stat_data   (fp_stat_data),
        .stat_resp   (fp_stat_resp),
        .event_valid (fp_event),
        .event_data  (fp_word)
    );

    stat_capture #(.STAT_W(SWC_STAT_W)) i_swc_stat (
        .clk_if      (clk_if),
        .rst_if      (rst_if),
        .stat_valid  (swc_stat_valid),
        .stat_data   (swc_stat_data),
        .stat_resp   (swc_stat_resp),
        .event_valid (swc_event),
        .event_data  (swc_word)
    );

    req_decode #(.REG_WIDTH(REG_WIDTH)) i_req_decode (
        .clk_if         (clk_if),
        .rst_if         (rst_if),
        .req_valid      (sys_req_valid),
        .req_wr         (sys_req_wr),
        .req_addr       (sys_req_addr),
        .req_data       (sys_req_data),
        .req_data_valid (sys_req_data_valid),
        .req_ack        (sys_req_ack),
        .cmd_addr       (cmd_addr),
        .rd_start       (rd_start),
        .rd_done        (rd_done),
        .wr_word        (wr_word),
        .wr_commit      (wr_commit),
        .wr_done        (wr_done)
    );

    counter_bank #(.REG_WIDTH(REG_WIDTH)) i_counter_bank (
        .clk_if     (clk_if),
        .rst_if     (rst_if),
        .fp_event   (fp_event),
        .fp_word    (fp_word),
        .swc_event  (swc_event),
        .swc_word   (swc_word),
        .cmd_addr   (cmd_addr),
        .rd_word    (rd_word),
        .wr_word    (wr_word),
        .wr_commit  (wr_commit),
        .wr_done    (wr_done),
        .conf_valid (fp_conf_valid),
        .conf_resp  (fp_conf_resp),
        .conf_type  (fp_conf_type),
        .conf_data  (fp_conf_data)
    );

    resp_serializer #(.REG_WIDTH(REG_WIDTH)) i_resp_serializer (
        .clk_if          (clk_if),
        .rst_if          (rst_if),
        .rd_start        (rd_start),
        .rd_word         (rd_word),
        .resp_data       (sys_resp_data),
        .resp_data_valid (sys_resp_data_valid),
        .rd_done         (rd_done)
    );

endmodule

/* verilog/resp_serializer.sv */
module resp_serializer import mgnt_pkg::*; #(
    parameter int REG_WIDTH = mgnt_pkg::REG_WIDTH
) (
    input  logic                 clk_if,
    input  logic                 rst_if,
    input  logic                 rd_start,
    input  logic [REG_WIDTH-1:0] rd_word,
    output logic [BYTE_W-1:0]    resp_data,
    output logic                 resp_data_valid,
    output logic                 rd_done
);

    localparam int NBYTES = REG_WIDTH / BYTE_W;
    localparam int CNT_W  = (NBYTES > 1) ? $clog2(NBYTES) : 1;
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(NBYTES - 1);

    logic [REG_WIDTH-1:0] shift_q;
    logic [CNT_W-1:0]     byte_cnt;

    // top byte of the shifter is on the bus
    assign resp_data = shift_q[REG_WIDTH-1 -: BYTE_W];
    assign rd_done   = resp_data_valid && (byte_cnt == LAST_BYTE);

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            resp_data_valid <= 1'b0;
            byte_cnt        <= '0;
        end else if (rd_start) begin
            resp_data_valid <= 1'b1;
            byte_cnt        <= '0;
        end else if (resp_data_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (rd_done) begin
                resp_data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_if) begin
        if (rd_start) begin
            shift_q <= rd_word;
        end else if (resp_data_valid) begin
            shift_q <= shift_q << BYTE_W;
        end
    end

    // a read burst is exactly one word long
    assert property (@(posedge clk_if) disable iff (!rst_if)
        $rose(resp_data_valid) |-> resp_data_valid [*NBYTES] ##1 !resp_data_valid);

endmodule

/* verilog/counter_bank.sv */
module counter_bank import mgnt_pkg::*; #(
    parameter int REG_WIDTH = mgnt_pkg::REG_WIDTH
) (
    input  logic                   clk_if,
    input  logic                   rst_if,
    input  logic                   fp_event,
    input  logic [FP_STAT_W-1:0]   fp_word,
    input  logic                   swc_event,
    input  logic [SWC_STAT_W-1:0]  swc_word,
    input  addr_t                  cmd_addr,
    output logic [REG_WIDTH-1:0]   rd_word,
    input  logic [REG_WIDTH-1:0]   wr_word,
    input  logic                   wr_commit,
    output logic                   wr_done,
    output logic                   conf_valid,
    input  logic                   conf_resp,
    output logic [CONF_TYPE_W-1:0] conf_type,
    output logic [CONF_DATA_W-1:0] conf_data
);

    localparam logic [REG_WIDTH-1:0] ONE = REG_WIDTH'(1);

    localparam logic [1:0] CF_IDLE = 2'd0;
    localparam logic [1:0] CF_BUSY = 2'd1;
    localparam logic [1:0] CF_DONE = 2'd2;

    if ((REG_WIDTH % BYTE_W) != 0 || REG_WIDTH < CONF_DATA_W) begin : g_width_check
        $error("REG_WIDTH must be a multiple of %0d and at least %0d", BYTE_W, CONF_DATA_W);
    end

    logic [REG_WIDTH-1:0] fp_cnt   [8];
    logic [REG_WIDTH-1:0] conf_reg [3];
    logic [REG_WIDTH-1:0] swc_cnt  [5];
    logic [7:0]           fp_inc;
    logic [4:0]           swc_inc;
    logic [1:0]           resp_sync;
    logic [1:0]           cf_state;
    logic                 is_conf;
    logic                 conf_start;

    //////////////////////////////////////////////////////////////////////
    // event counters

    // counter index is the low address bits, both banks start aligned
    always_comb begin
        fp_inc = '0;
        fp_inc[ADDR_FP_UNICAST[2:0]]     = fp_word[FP_BIT_UNICAST];
        fp_inc[ADDR_FP_GROUPCAST[2:0]]   = fp_word[FP_BIT_GROUPCAST];
        fp_inc[ADDR_FP_BROADCAST[2:0]]   = fp_word[FP_BIT_BROADCAST];
        fp_inc[ADDR_FP_SRC_LEARN[2:0]]   = fp_word[FP_BIT_SRC_LEARN];
        fp_inc[ADDR_FP_SRC_EVICT[2:0]]   = fp_word[FP_BIT_SRC_EVICT];
        fp_inc[ADDR_FP_BP[2:0]]          = fp_word[FP_BIT_BP];
        // these two count on a cleared bit
        fp_inc[ADDR_FP_DST_MISS[2:0]]    = !fp_word[FP_BIT_DST_HIT];
        fp_inc[ADDR_FP_MAC_INVALID[2:0]] = !fp_word[FP_BIT_SRC_VALID];

        swc_inc = '0;
        swc_inc[ADDR_SWC_PKT[2:0]]      = (swc_word[SWC_BIT_QC_FULL:SWC_BIT_NO_ROUTE] == '0);
        swc_inc[ADDR_SWC_NO_ROUTE[2:0]] = swc_word[SWC_BIT_NO_ROUTE];
        swc_inc[ADDR_SWC_FQ_EMPTY[2:0]] = swc_word[SWC_BIT_FQ_EMPTY];
        swc_inc[ADDR_SWC_QC_FULL[2:0]]  = swc_word[SWC_BIT_QC_FULL];
        swc_inc[ADDR_SWC_BP[2:0]]       = swc_word[SWC_BIT_BP];
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            for (int i = 0; i < 8; i++) begin
                fp_cnt[i] <= '0;
            end
            for (int i = 0; i < 5; i++) begin
                swc_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (fp_event && fp_inc[i]) begin
                    fp_cnt[i] <= fp_cnt[i] + ONE;
                end
            end
            for (int i = 0; i < 5; i++) begin
                if (swc_event && swc_inc[i]) begin
                    swc_cnt[i] <= swc_cnt[i] + ONE;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // config registers and config channel

    assign is_conf    = (cmd_addr == ADDR_CONF_FWD_DIS) || (cmd_addr == ADDR_CONF_LRN_DIS) ||
                        (cmd_addr == ADDR_CONF_AGING);
    assign conf_start = wr_commit && is_conf && (cf_state == CF_IDLE);
    assign conf_valid = (cf_state == CF_BUSY);

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            for (int i = 0; i < 3; i++) begin
                conf_reg[i] <= '0;
            end
        end else if (conf_start) begin
            conf_reg[cmd_addr[1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk_if) begin
        if (conf_start) begin
            conf_type <= cmd_addr[CONF_TYPE_W-1:0];
            conf_data <= wr_word[CONF_DATA_W-1:0];
        end
    end

    // done one cycle after commit, or one cycle after conf_valid drops
    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            resp_sync <= '0;
            cf_state  <= CF_IDLE;
            wr_done   <= 1'b0;
        end else begin
            resp_sync <= {resp_sync[0], conf_resp};
            wr_done   <= (wr_commit && !is_conf) || (cf_state == CF_DONE);
            case (cf_state)
                CF_IDLE: cf_state <= conf_start ? CF_BUSY : CF_IDLE;
                CF_BUSY: cf_state <= resp_sync[1] ? CF_DONE : CF_BUSY;
                default: cf_state <= CF_IDLE;
            endcase
        end
    end

    // read mux, unmapped addresses give zero
    always_comb begin
        rd_word = '0;
        if (cmd_addr <= ADDR_FP_MAC_INVALID) begin
            rd_word = fp_cnt[cmd_addr[2:0]];
        end else if (is_conf) begin
            rd_word = conf_reg[cmd_addr[1:0]];
        end else if (cmd_addr >= ADDR_SWC_PKT && cmd_addr <= ADDR_SWC_BP) begin
            rd_word = swc_cnt[cmd_addr[2:0]];
        end
    end

    assert property (@(posedge clk_if) disable iff (!rst_if)
        conf_valid && $past(conf_valid) |-> $stable(conf_type) && $stable(conf_data));

endmodule

/* verilog/req_decode.sv */
module req_decode import mgnt_pkg::*; #(
    parameter int REG_WIDTH = mgnt_pkg::REG_WIDTH
) (
    input  logic                 clk_if,
    input  logic                 rst_if,
    input  logic                 req_valid,
    input  logic                 req_wr,
    input  addr_t                req_addr,
    input  logic [BYTE_W-1:0]    req_data,
    input  logic                 req_data_valid,
    output logic                 req_ack,
    output addr_t                cmd_addr,
    output logic                 rd_start,
    input  logic                 rd_done,
    output logic [REG_WIDTH-1:0] wr_word,
    output logic                 wr_commit,
    input  logic                 wr_done
);

    localparam int NBYTES = REG_WIDTH / BYTE_W;
    localparam int CNT_W  = (NBYTES > 1) ? $clog2(NBYTES) : 1;
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(NBYTES - 1);

    localparam logic [2:0] ST_IDLE       = 3'd0;
    localparam logic [2:0] ST_READ       = 3'd1;
    localparam logic [2:0] ST_WR_COLLECT = 3'd2;
    localparam logic [2:0] ST_WR_WAIT    = 3'd3;
    localparam logic [2:0] ST_ACK        = 3'd4;

    logic [2:0]                  state;
    logic [2:0]                  state_next;
    logic [CNT_W-1:0]            byte_cnt;
    logic [REG_WIDTH-BYTE_W-1:0] wr_head;

    // the last byte completes the word in the same cycle
    assign wr_commit = (state == ST_WR_COLLECT) && req_data_valid && (byte_cnt == LAST_BYTE);
    assign wr_word   = {wr_head, req_data};

    // ack goes up as soon as counter_bank reports the write done
    assign req_ack = (state == ST_ACK) || ((state == ST_WR_WAIT) && wr_done);

    always_comb begin
        case (state)
            ST_IDLE:       state_next = !req_valid ? ST_IDLE :
                                        (req_wr ? ST_WR_COLLECT : ST_READ);
            ST_READ:       state_next = rd_done ? ST_ACK : ST_READ;
            ST_WR_COLLECT: state_next = wr_commit ? ST_WR_WAIT : ST_WR_COLLECT;
            ST_WR_WAIT:    state_next = wr_done ? ST_ACK : ST_WR_WAIT;
            ST_ACK:        state_next = req_valid ? ST_ACK : ST_IDLE;
            default:       state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            state    <= ST_IDLE;
            rd_start <= 1'b0;
            byte_cnt <= '0;
            cmd_addr <= '0;
        end else begin
            state    <= state_next;
            // read word is taken one cycle after the address is latched
            rd_start <= (state == ST_IDLE) && req_valid && !req_wr;
            if (state == ST_IDLE) begin
                byte_cnt <= '0;
                if (req_valid) begin
                    cmd_addr <= req_addr;
                end
            end else if ((state == ST_WR_COLLECT) && req_data_valid) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // most significant byte arrives first
    always_ff @(posedge clk_if) begin
        if ((state == ST_WR_COLLECT) && req_data_valid) begin
            wr_head <= wr_word[REG_WIDTH-BYTE_W-1:0];
        end
    end

    assert property (@(posedge clk_if) disable iff (!rst_if)
        req_ack |-> $past(req_valid));

endmodule

/* verilog/stat_capture.sv */
module stat_capture import mgnt_pkg::*; #(
    parameter int STAT_W = FP_STAT_W
) (
    input  logic              clk_if,
    input  logic              rst_if,
    input  logic              stat_valid,
    input  logic [STAT_W-1:0] stat_data,
    output logic              stat_resp,
    output logic              event_valid,
    output logic [STAT_W-1:0] event_data
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_CAPTURE = 2'd1;
    localparam logic [1:0] ST_HOLD    = 2'd2;

    logic [1:0] valid_sync;
    logic [1:0] state;
    logic [1:0] state_next;

    always_comb begin
        case (state)
            ST_IDLE:    state_next = valid_sync[1] ? ST_CAPTURE : ST_IDLE;
            ST_CAPTURE: state_next = ST_HOLD;
            // wait for the source to drop valid
            ST_HOLD:    state_next = valid_sync[1] ? ST_HOLD : ST_IDLE;
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!rst_if) begin
            valid_sync  <= '0;
            state       <= ST_IDLE;
            event_valid <= 1'b0;
            stat_resp   <= 1'b0;
        end else begin
            valid_sync  <= {valid_sync[0], stat_valid};
            state       <= state_next;
            event_valid <= (state == ST_CAPTURE);
            stat_resp   <= (state == ST_HOLD);
        end
    end

    // source keeps the word stable while valid is up
    always_ff @(posedge clk_if) begin
        if (state == ST_CAPTURE) begin
            event_data <= stat_data;
        end
    end

    // one counter update per handshake
    assert property (@(posedge clk_if) disable iff (!rst_if)
        event_valid |=> !event_valid);

endmodule

/* verilog/mgnt_pkg.sv */
package mgnt_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    // default register width, switch_ctrl may override it
    parameter int REG_WIDTH   = 32;
    parameter int BYTE_W      = 8;
    parameter int FP_STAT_W   = 8;
    parameter int SWC_STAT_W  = 4;
    parameter int CONF_DATA_W = 16;
    parameter int CONF_TYPE_W = 2;

    typedef logic [7:0] addr_t;

    //////////////////////////////////////////////////////////////////////
    // register map

    // frame-processing counters, read only
    parameter addr_t ADDR_FP_UNICAST     = 8'h00;
    parameter addr_t ADDR_FP_GROUPCAST   = 8'h01;
    parameter addr_t ADDR_FP_BROADCAST   = 8'h02;
    parameter addr_t ADDR_FP_SRC_LEARN   = 8'h03;
    parameter addr_t ADDR_FP_SRC_EVICT   = 8'h04;
    parameter addr_t ADDR_FP_DST_MISS    = 8'h05;
    parameter addr_t ADDR_FP_BP          = 8'h06;
    parameter addr_t ADDR_FP_MAC_INVALID = 8'h07;
    // forwarding-table config, read/write, low two bits give the conf type
    parameter addr_t ADDR_CONF_FWD_DIS   = 8'h08;
    parameter addr_t ADDR_CONF_LRN_DIS   = 8'h09;
    parameter addr_t ADDR_CONF_AGING     = 8'h0A;
    // switch-core counters, read only
    parameter addr_t ADDR_SWC_PKT        = 8'h10;
    parameter addr_t ADDR_SWC_NO_ROUTE   = 8'h11;
    parameter addr_t ADDR_SWC_FQ_EMPTY   = 8'h12;
    parameter addr_t ADDR_SWC_QC_FULL    = 8'h13;
    parameter addr_t ADDR_SWC_BP         = 8'h14;

    //////////////////////////////////////////////////////////////////////
    // status word bit positions

    // bits 2..0 carry the destination MAC type
    parameter int FP_BIT_UNICAST   = 0;
    parameter int FP_BIT_GROUPCAST = 1;
    parameter int FP_BIT_BROADCAST = 2;
    parameter int FP_BIT_DST_HIT   = 3;
    parameter int FP_BIT_SRC_VALID = 4;
    parameter int FP_BIT_SRC_LEARN = 5;
    // learn hit a full table
    parameter int FP_BIT_SRC_EVICT = 6;
    parameter int FP_BIT_BP        = 7;

    parameter int SWC_BIT_NO_ROUTE = 0;
    parameter int SWC_BIT_FQ_EMPTY = 1;
    parameter int SWC_BIT_QC_FULL  = 2;
    parameter int SWC_BIT_BP       = 3;

endpackage
